// ==== Bender.yml ====
package:
  name: be_ctrl

sources:
  - src/be_isa_pkg.sv
  - src/fe_cmd_pkg.sv
  - src/be_decode.sv
  - src/be_execute.sv
  - src/be_director.sv
  - src/be_top.sv
  - target: test
    files:
      - bench/be_properties.sv
      - bench/be_tb.sv

// ==== bench/be_properties.sv ====
/*
 * Front-end command protocol checks
 * Bound to the back-end top level
 */
`timescale 1ns/1ps
`default_nettype none

module be_properties (
   input  wire logic          clk_i,
   input  wire logic          reset_i,
   input  wire logic          fe_cmd_ready_i,
   input  fe_cmd_pkg::fe_cmd_s fe_cmd_o,
   input  wire logic          fe_cmd_v_o,
   input  wire logic          flush_o
);

   int unsigned prop_fails = 0;
   logic        boot_cmd;
   logic        boot_sent_r;

   assign boot_cmd = fe_cmd_v_o && (fe_cmd_o.opcode == fe_cmd_pkg::e_op_state_reset);

   // Set once the boot command has gone out
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         boot_sent_r <= 1'b0;
      else if (boot_cmd)
         boot_sent_r <= 1'b1;
   end

   cmd_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
      fe_cmd_v_o |-> fe_cmd_ready_i)
   else
   begin
      $error("command sent while the front end was not ready");
      prop_fails++;
   end

   quiet_after_reset: assert property (@(posedge clk_i)
      $fell(reset_i) |-> (!fe_cmd_v_o && !flush_o))
   else
   begin
      $error("command or flush right after reset");
      prop_fails++;
   end

   single_boot: assert property (@(posedge clk_i) disable iff (reset_i)
      boot_cmd |-> !boot_sent_r)
   else
   begin
      $error("second state reset command after reset");
      prop_fails++;
   end

endmodule

bind be_top be_properties be_properties_inst (
   .clk_i          (clk_i),
   .reset_i        (reset_i),
   .fe_cmd_ready_i (fe_cmd_ready_i),
   .fe_cmd_o       (fe_cmd_o),
   .fe_cmd_v_o     (fe_cmd_v_o),
   .flush_o        (flush_o)
);

`default_nettype wire

// ==== bench/be_tb.sv ====
/*
 * Back-end control testbench
 * Boots the PC director, runs directed and random instruction streams
 * and checks every front-end command against a reference PC model
 */
`timescale 1ns/1ps
`default_nettype none

module be_tb;

   // Stimulus runs about 200 cycles
   localparam int          max_cycles = 400;
   localparam logic [31:0] boot_pc    = 32'h0000_1000;

   logic                   clk_i;
   logic                   reset_i;
   be_isa_pkg::be_issue_s  issue;
   fe_cmd_pkg::boot_cfg_s  boot_cfg;
   logic [31:0]            tvec;
   logic [31:0]            epc;
   logic                   fe_cmd_ready;
   fe_cmd_pkg::fe_cmd_s    fe_cmd;
   logic                   fe_cmd_v;
   logic                   flush;
   logic [31:0]            expected_npc;
   logic [31:0]            pc;

   // Values applied at the next falling edge
   fe_cmd_pkg::boot_cfg_s  boot_nxt;
   logic                   ready_nxt;

   // Reference model of the director
   // States 0 reset, 1 boot and 2 run
   logic [31:0]            ref_npc = '0;
   logic [31:0]            ref_pc = '0;
   logic                   ref_pending = 1'b0;
   int                     ref_state = 0;
   be_isa_pkg::be_issue_s  in_flight[$];
   logic [31:0]            stim_pc;
   int                     cycles = 0;

   be_top be_top_inst (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .issue_i        (issue),
      .boot_cfg_i     (boot_cfg),
      .tvec_i         (tvec),
      .epc_i          (epc),
      .fe_cmd_ready_i (fe_cmd_ready),
      .fe_cmd_o       (fe_cmd),
      .fe_cmd_v_o     (fe_cmd_v),
      .flush_o        (flush),
      .expected_npc_o (expected_npc),
      .pc_o           (pc)
   );

   always #4 clk_i = ~clk_i;

   always @(posedge clk_i)
   begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("timeout: the run did not finish within %0d cycles", max_cycles);
         $display(">>> FAIL");
         $fatal(1, "timeout");
      end
   end

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "output check failed");
   endtask

   function automatic logic is_trap(input be_isa_pkg::be_opcode_e op);
      return (op == be_isa_pkg::e_ecall) || (op > be_isa_pkg::e_mret);
   endfunction

   function automatic logic is_br_or_jmp(input be_isa_pkg::be_opcode_e op);
      return op inside {be_isa_pkg::e_beq, be_isa_pkg::e_bne, be_isa_pkg::e_blt,
                        be_isa_pkg::e_jal, be_isa_pkg::e_jalr};
   endfunction

   // Architectural successor of an instruction
   function automatic logic [31:0] correct_npc(input be_isa_pkg::be_issue_s p);
      logic [31:0] imm;
      logic        taken;
      imm = {{16{p.imm[15]}}, p.imm};
      case (p.opcode)
         be_isa_pkg::e_beq:  taken = (p.rs1 == p.rs2);
         be_isa_pkg::e_bne:  taken = (p.rs1 != p.rs2);
         be_isa_pkg::e_blt:  taken = ($signed(p.rs1) < $signed(p.rs2));
         be_isa_pkg::e_jal:  taken = 1'b1;
         be_isa_pkg::e_jalr: taken = 1'b1;
         default:            taken = 1'b0;
      endcase
      if (is_trap(p.opcode))
         return {tvec[31:2], 2'b00};
      else if (p.opcode == be_isa_pkg::e_mret)
         return epc;
      else if (taken && p.opcode == be_isa_pkg::e_jalr)
         return (p.rs1 + imm) & ~32'd1;
      else if (taken)
         return p.pc + imm;
      else
         return p.pc + 32'd4;
   endfunction

   function automatic be_isa_pkg::be_issue_s make_instr(input logic [31:0] at_pc,
                                                        input be_isa_pkg::be_opcode_e op,
                                                        input logic [15:0] imm);
      be_isa_pkg::be_issue_s p;
      p.valid  = 1'b1;
      p.pc     = at_pc;
      p.opcode = op;
      p.imm    = imm;
      p.rs1    = $urandom;
      p.rs2    = ($urandom_range(0, 3) == 0) ? p.rs1 : $urandom;
      p.meta   = at_pc[9:2];
      return p;
   endfunction

   // Predicts the command for the instruction now in the director
   task automatic check_outputs(input be_isa_pkg::be_issue_s p);
      logic                acc;
      logic                trap_acc;
      logic                want;
      logic                exp_v;
      logic                exp_flush;
      logic [31:0]         npc_n;
      fe_cmd_pkg::fe_cmd_s exp;
      acc      = p.valid && (p.pc == ref_npc);
      trap_acc = acc && is_trap(p.opcode);
      npc_n    = correct_npc(p);
      exp      = '0;
      want     = 1'b1;
      if (ref_state == 1)
      begin
         exp.opcode = fe_cmd_pkg::e_op_state_reset;
         exp.vaddr  = ref_npc;
      end
      else if (acc && p.opcode == be_isa_pkg::e_fencei)
      begin
         exp.opcode = fe_cmd_pkg::e_op_icache_fence;
         exp.vaddr  = npc_n;
      end
      else if (trap_acc || (acc && p.opcode == be_isa_pkg::e_mret))
      begin
         exp.opcode = fe_cmd_pkg::e_op_pc_redirection;
         exp.vaddr  = npc_n;
         exp.subop  = trap_acc ? fe_cmd_pkg::e_subop_trap : fe_cmd_pkg::e_subop_ret;
         exp.meta   = p.meta;
      end
      else if (p.valid && !acc)
      begin
         exp.opcode = fe_cmd_pkg::e_op_pc_redirection;
         exp.vaddr  = ref_npc;
         exp.subop  = fe_cmd_pkg::e_subop_branch_mispredict;
         exp.reason = ref_pending ? fe_cmd_pkg::e_incorrect_prediction
                                  : fe_cmd_pkg::e_not_a_branch;
         exp.meta   = p.meta;
      end
      else if (acc && ref_pending)
      begin
         exp.opcode = fe_cmd_pkg::e_op_attaboy;
         exp.vaddr  = p.pc;
         exp.meta   = p.meta;
      end
      else
         want = 1'b0;
      exp_v     = want && fe_cmd_ready;
      exp_flush = (exp_v && (exp.opcode == fe_cmd_pkg::e_op_state_reset ||
                             exp.opcode == fe_cmd_pkg::e_op_icache_fence)) || trap_acc;

      assert (fe_cmd_v === exp_v) else report_mismatch("fe_cmd_v_o", fe_cmd_v, exp_v);
      assert (flush === exp_flush) else report_mismatch("flush_o", flush, exp_flush);
      assert (expected_npc === ref_npc)
         else report_mismatch("expected_npc_o", expected_npc, ref_npc);
      assert (pc === ref_pc) else report_mismatch("pc_o", pc, ref_pc);
      if (exp_v)
      begin
         assert (fe_cmd.opcode === exp.opcode)
            else report_mismatch("fe_cmd_o.opcode", fe_cmd.opcode, exp.opcode);
         assert (fe_cmd.vaddr === exp.vaddr)
            else report_mismatch("fe_cmd_o.vaddr", fe_cmd.vaddr, exp.vaddr);
      end
      if (exp_v && exp.opcode == fe_cmd_pkg::e_op_pc_redirection)
      begin
         assert (fe_cmd.subop === exp.subop)
            else report_mismatch("fe_cmd_o.subop", fe_cmd.subop, exp.subop);
         assert (fe_cmd.reason === exp.reason)
            else report_mismatch("fe_cmd_o.reason", fe_cmd.reason, exp.reason);
      end
      if (exp_v && (exp.opcode == fe_cmd_pkg::e_op_pc_redirection ||
                    exp.opcode == fe_cmd_pkg::e_op_attaboy))
      begin
         assert (fe_cmd.meta === exp.meta)
            else report_mismatch("fe_cmd_o.meta", fe_cmd.meta, exp.meta);
      end

      if (boot_cfg.start_pc_w_v)
      begin
         ref_pc  = ref_npc;
         ref_npc = boot_cfg.start_pc;
      end
      else if (acc)
      begin
         ref_pc  = ref_npc;
         ref_npc = npc_n;
      end
      if (p.valid)
         ref_pending = is_br_or_jmp(p.opcode);
      if (ref_state == 0 && !boot_cfg.freeze)
         ref_state = 1;
      else if (ref_state == 1 && exp_v)
         ref_state = 2;
   endtask

   // Drives one cycle at the falling edge and checks the packet issued two cycles back
   task automatic step(input be_isa_pkg::be_issue_s p);
      be_isa_pkg::be_issue_s done;
      @(negedge clk_i);
      issue        = p;
      fe_cmd_ready = ready_nxt;
      boot_cfg     = boot_nxt;
      in_flight.push_back(p);
      #2;
      done = in_flight.pop_front();
      check_outputs(done);
   endtask

   task automatic issue_next(input be_isa_pkg::be_opcode_e op, input logic [15:0] imm);
      be_isa_pkg::be_issue_s p;
      p       = make_instr(stim_pc, op, imm);
      stim_pc = correct_npc(p);
      step(p);
   endtask

   // Operands force the branch taken, then the successor lands on or off target
   task automatic taken_branch(input be_isa_pkg::be_opcode_e op, input logic [15:0] imm,
                               input logic follow);
      be_isa_pkg::be_issue_s p;
      p     = make_instr(stim_pc, op, imm);
      p.rs1 = 32'h8000_0000 | $urandom;
      p.rs2 = (op == be_isa_pkg::e_beq) ? p.rs1 : {1'b0, p.rs1[30:0]};
      step(p);
      stim_pc = correct_npc(p);
      if (!follow)
         step(make_instr(p.pc + 32'd4, be_isa_pkg::e_alu, 16'h0000));
      issue_next(be_isa_pkg::e_alu, 16'h0010);
   endtask

   initial
   begin
      void'($urandom(32'h7e63_ccb3));
      clk_i        = 1'b0;
      reset_i      = 1'b1;
      issue        = '0;
      boot_cfg     = '0;
      boot_cfg.freeze = 1'b1;
      boot_nxt     = boot_cfg;
      tvec         = 32'h0000_2103;
      epc          = 32'h0000_0840;
      fe_cmd_ready = 1'b0;
      ready_nxt    = 1'b0;
      in_flight.push_back('0);
      in_flight.push_back('0);
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;

      // Boot with the front end busy at first
      boot_nxt.start_pc_w_v = 1'b1;
      boot_nxt.start_pc     = boot_pc;
      step('0);
      boot_nxt.start_pc_w_v = 1'b0;
      boot_nxt.freeze       = 1'b0;
      repeat (4) step('0);
      ready_nxt = 1'b1;
      repeat (3) step('0);
      stim_pc = boot_pc;

      repeat (6) issue_next(be_isa_pkg::e_alu, 16'($urandom));

      taken_branch(be_isa_pkg::e_beq, 16'h0040, 1'b1);
      taken_branch(be_isa_pkg::e_blt, 16'hffe0, 1'b1);
      taken_branch(be_isa_pkg::e_jal, 16'h0100, 1'b1);
      taken_branch(be_isa_pkg::e_beq, 16'h0040, 1'b0);
      taken_branch(be_isa_pkg::e_blt, 16'hffe0, 1'b0);
      taken_branch(be_isa_pkg::e_jal, 16'h0080, 1'b0);
      taken_branch(be_isa_pkg::e_jalr, 16'h0024, 1'b1);

      // Wrong PC after a plain ALU instruction
      issue_next(be_isa_pkg::e_alu, 16'h0000);
      step(make_instr(stim_pc + 32'd8, be_isa_pkg::e_alu, 16'h0000));
      issue_next(be_isa_pkg::e_alu, 16'h0000);

      issue_next(be_isa_pkg::e_fencei, 16'h0000);
      issue_next(be_isa_pkg::e_ecall, 16'h0000);
      issue_next(be_isa_pkg::e_alu, 16'h0000);
      issue_next(be_isa_pkg::be_opcode_e'(4'hc), 16'h0000);
      issue_next(be_isa_pkg::e_mret, 16'h0000);
      issue_next(be_isa_pkg::e_alu, 16'h0000);

      // Mismatch while the front end is busy is dropped
      issue_next(be_isa_pkg::e_alu, 16'h0000);
      step(make_instr(stim_pc + 32'd8, be_isa_pkg::e_alu, 16'h0000));
      step('0);
      ready_nxt = 1'b0;
      step('0);
      ready_nxt = 1'b1;
      repeat (2) step('0);

      repeat (140)
      begin
         if ($urandom_range(0, 9) == 0)
            step(make_instr(stim_pc + 32'd12, be_isa_pkg::e_alu, 16'h0000));
         issue_next(be_isa_pkg::be_opcode_e'($urandom_range(0, 5)),
                    16'($urandom) & 16'hfffc);
      end
      repeat (3) step('0);

      if (be_top_inst.be_properties_inst.prop_fails == 0)
      begin
         $display(">>> PASS");
         $finish;
      end
      else
      begin
         $display("protocol properties failed %0d times",
                  be_top_inst.be_properties_inst.prop_fails);
         $display(">>> FAIL");
         $fatal(1, "property check failed");
      end
   end

endmodule

`default_nettype wire

// ==== sources.f ====
src/be_isa_pkg.sv
src/fe_cmd_pkg.sv
src/be_decode.sv
src/be_execute.sv
src/be_director.sv
src/be_top.sv
bench/be_properties.sv
bench/be_tb.sv

// ==== src/be_decode.sv ====
/*
 * Back-end decode stage
 * Classifies each issue packet and registers the control bundle
 */
`timescale 1ns/1ps
`default_nettype none

module be_decode (
   input  wire logic                   clk_i,
   input  wire logic                   reset_i,
   input  be_isa_pkg::be_issue_s       issue_i,
   output be_isa_pkg::be_decode_s      dec_o
);

   localparam int ext_width = be_isa_pkg::vaddr_width - be_isa_pkg::imm_width;

   be_isa_pkg::be_decode_s dec_n;
   be_isa_pkg::be_decode_s dec_r;

   always_comb
   begin
      dec_n       = '0;
      dec_n.valid = issue_i.valid;
      dec_n.pc    = issue_i.pc;
      dec_n.imm   = {{ext_width{issue_i.imm[be_isa_pkg::imm_width-1]}}, issue_i.imm};
      dec_n.rs1   = issue_i.rs1;
      dec_n.rs2   = issue_i.rs2;
      dec_n.meta  = issue_i.meta;

      case (issue_i.opcode)
         be_isa_pkg::e_alu:
         begin
            // Plain sequential instruction
         end
         be_isa_pkg::e_beq:
         begin
            dec_n.is_branch = 1'b1;
            dec_n.cmp       = be_isa_pkg::e_cmp_eq;
         end
         be_isa_pkg::e_bne:
         begin
            dec_n.is_branch = 1'b1;
            dec_n.cmp       = be_isa_pkg::e_cmp_ne;
         end
         be_isa_pkg::e_blt:
         begin
            dec_n.is_branch = 1'b1;
            dec_n.cmp       = be_isa_pkg::e_cmp_lt;
         end
         be_isa_pkg::e_jal:    dec_n.is_jump = 1'b1;
         be_isa_pkg::e_jalr:
         begin
            dec_n.is_jump       = 1'b1;
            dec_n.jump_indirect = 1'b1;
         end
         be_isa_pkg::e_fencei: dec_n.fencei = 1'b1;
         be_isa_pkg::e_ecall:  dec_n.trap   = 1'b1;
         be_isa_pkg::e_mret:   dec_n.ret    = 1'b1;
         // Illegal instruction traps
         default:              dec_n.trap   = 1'b1;
      endcase
   end

   // Only the valid bit is cleared, later stages gate on it
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         dec_r.valid <= 1'b0;
      else
         dec_r <= dec_n;
   end

   assign dec_o = dec_r;

endmodule

`default_nettype wire

// ==== src/be_director.sv ====
/*
 * PC director
 * Tracks the expected next PC, detects mispredictions and issues
 * boot, fence, redirect and attaboy commands to the front end
 */
`timescale 1ns/1ps
`default_nettype none

module be_director (
   input  wire logic                                clk_i,
   input  wire logic                                reset_i,
   input  fe_cmd_pkg::boot_cfg_s                    boot_cfg_i,
   input  be_isa_pkg::be_status_s                   status_i,
   input  wire logic [be_isa_pkg::vaddr_width-1:0]  tvec_i,
   input  wire logic [be_isa_pkg::vaddr_width-1:0]  epc_i,
   input  wire logic                                fe_cmd_ready_i,
   output fe_cmd_pkg::fe_cmd_s                      fe_cmd_o,
   output logic                                     fe_cmd_v_o,
   output logic                                     flush_o,
   output logic [be_isa_pkg::vaddr_width-1:0]       expected_npc_o,
   output logic [be_isa_pkg::vaddr_width-1:0]       pc_o
);

   localparam int vw = be_isa_pkg::vaddr_width;

   typedef enum logic [1:0] {
      e_reset = 2'd0,
      e_boot  = 2'd1,
      e_run   = 2'd2
   } dir_state_e;

   dir_state_e          state_r;
   dir_state_e          state_n;
   logic [vw-1:0]       npc_r;
   logic [vw-1:0]       npc_n;
   logic [vw-1:0]       pc_r;
   logic [vw-1:0]       npc_plus4;
   logic                npc_w_v;
   logic                mismatch;
   logic                accepted;
   logic                trap_v;
   logic                ret_v;
   logic                attaboy_pending_r;
   fe_cmd_pkg::fe_cmd_s fe_cmd;
   logic                fe_cmd_v;

   assign mismatch = (status_i.ex_pc != npc_r);
   assign accepted = status_i.ex_v & ~mismatch;

   // Trap and return only count on the expected path
   assign trap_v = accepted & status_i.trap_v;
   assign ret_v  = accepted & status_i.ret_v;

   assign npc_plus4 = npc_r + vw'(4);

   always_comb
   begin
      if (boot_cfg_i.start_pc_w_v)
         npc_n = boot_cfg_i.start_pc;
      else if (trap_v)
         npc_n = {tvec_i[vw-1:2], 2'b00};
      else if (ret_v)
         npc_n = epc_i;
      else if (status_i.btaken)
         npc_n = status_i.br_tgt;
      else
         npc_n = npc_plus4;
   end

   assign npc_w_v = boot_cfg_i.start_pc_w_v | accepted;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         npc_r <= '0;
         pc_r  <= '0;
      end
      else if (npc_w_v)
      begin
         npc_r <= npc_n;
         pc_r  <= npc_r;
      end
   end

   // Remembers whether the last executed instruction could be mispredicted
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         attaboy_pending_r <= 1'b0;
      else if (status_i.ex_v)
         attaboy_pending_r <= status_i.br_or_jmp;
   end

   // Boot sequencing
   always_comb
   begin
      case (state_r)
         e_reset: state_n = boot_cfg_i.freeze ? e_reset : e_boot;
         e_boot:  state_n = fe_cmd_v ? e_run : e_boot;
         e_run:   state_n = e_run;
         default: state_n = e_reset;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         state_r <= e_reset;
      else
         state_r <= state_n;
   end

   // Command selection, a command is dropped when the front end is busy
   always_comb
   begin
      fe_cmd   = '0;
      fe_cmd_v = 1'b0;

      if (state_r == e_boot)
      begin
         fe_cmd.opcode = fe_cmd_pkg::e_op_state_reset;
         fe_cmd.vaddr  = npc_r;
         fe_cmd_v      = fe_cmd_ready_i;
      end
      else if (accepted & status_i.fencei_v)
      begin
         fe_cmd.opcode = fe_cmd_pkg::e_op_icache_fence;
         fe_cmd.vaddr  = npc_n;
         fe_cmd_v      = fe_cmd_ready_i;
      end
      else if (trap_v | ret_v)
      begin
         fe_cmd.opcode = fe_cmd_pkg::e_op_pc_redirection;
         fe_cmd.vaddr  = npc_n;
         fe_cmd.subop  = trap_v ? fe_cmd_pkg::e_subop_trap : fe_cmd_pkg::e_subop_ret;
         fe_cmd.reason = fe_cmd_pkg::e_not_a_branch;
         fe_cmd.meta   = status_i.meta;
         fe_cmd_v      = fe_cmd_ready_i;
      end
      else if (status_i.ex_v & mismatch)
      begin
         fe_cmd.opcode = fe_cmd_pkg::e_op_pc_redirection;
         fe_cmd.vaddr  = npc_r;
         fe_cmd.subop  = fe_cmd_pkg::e_subop_branch_mispredict;
         fe_cmd.reason = attaboy_pending_r ? fe_cmd_pkg::e_incorrect_prediction
                                           : fe_cmd_pkg::e_not_a_branch;
         fe_cmd.meta   = status_i.meta;
         fe_cmd_v      = fe_cmd_ready_i;
      end
      else if (accepted & attaboy_pending_r)
      begin
         fe_cmd.opcode = fe_cmd_pkg::e_op_attaboy;
         fe_cmd.vaddr  = status_i.ex_pc;
         fe_cmd.meta   = status_i.meta;
         fe_cmd_v      = fe_cmd_ready_i;
      end
   end

   // Mispredicts and attaboys leave the pipeline alone
   assign flush_o = (fe_cmd_v & (fe_cmd.opcode != fe_cmd_pkg::e_op_attaboy)
                              & (fe_cmd.opcode != fe_cmd_pkg::e_op_pc_redirection))
                    | trap_v;

   assign fe_cmd_o       = fe_cmd;
   assign fe_cmd_v_o     = fe_cmd_v;
   assign expected_npc_o = npc_r;
   assign pc_o           = pc_r;

endmodule

`default_nettype wire

// ==== src/be_execute.sv ====
/*
 * Back-end execute stage
 * Resolves branches and jumps and registers the status bundle
 * for the PC director
 */
`timescale 1ns/1ps
`default_nettype none

module be_execute (
   input  wire logic                   clk_i,
   input  wire logic                   reset_i,
   input  be_isa_pkg::be_decode_s      dec_i,
   output be_isa_pkg::be_status_s      status_o
);

   logic                               cond;
   logic                               taken;
   logic [be_isa_pkg::vaddr_width-1:0] tgt_sum;
   be_isa_pkg::be_status_s             status_n;
   be_isa_pkg::be_status_s             status_r;

   // Branch condition on the operands
   always_comb
   begin
      case (dec_i.cmp)
         be_isa_pkg::e_cmp_eq: cond = (dec_i.rs1 == dec_i.rs2);
         be_isa_pkg::e_cmp_ne: cond = (dec_i.rs1 != dec_i.rs2);
         be_isa_pkg::e_cmp_lt: cond = ($signed(dec_i.rs1) < $signed(dec_i.rs2));
         default:              cond = 1'b0;
      endcase
   end

   assign taken = dec_i.is_jump | (dec_i.is_branch & cond);

   // jalr is register relative, everything else PC relative
   assign tgt_sum = dec_i.jump_indirect ? dec_i.rs1 + dec_i.imm : dec_i.pc + dec_i.imm;

   always_comb
   begin
      status_n.ex_v      = dec_i.valid;
      status_n.ex_pc     = dec_i.pc;
      status_n.br_or_jmp = dec_i.valid & (dec_i.is_branch | dec_i.is_jump);
      status_n.btaken    = dec_i.valid & taken;
      status_n.br_tgt    = {tgt_sum[be_isa_pkg::vaddr_width-1:1],
                            tgt_sum[0] & ~dec_i.jump_indirect};
      status_n.fencei_v  = dec_i.valid & dec_i.fencei;
      status_n.trap_v    = dec_i.valid & dec_i.trap;
      status_n.ret_v     = dec_i.valid & dec_i.ret;
      status_n.meta      = dec_i.meta;
   end

   // Control flags cleared on reset, PCs and metadata left alone
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         status_r.ex_v      <= 1'b0;
         status_r.br_or_jmp <= 1'b0;
         status_r.btaken    <= 1'b0;
         status_r.fencei_v  <= 1'b0;
         status_r.trap_v    <= 1'b0;
         status_r.ret_v     <= 1'b0;
      end
      else
         status_r <= status_n;
   end

   assign status_o = status_r;

endmodule

`default_nettype wire

// ==== src/be_isa_pkg.sv ====
/*
 * Back-end ISA package
 * Widths, the opcode enum and the issue, decode and status bundles
 * that travel down the back-end pipeline
 */
`default_nettype none

package be_isa_pkg;

   localparam int vaddr_width = 32;
   localparam int data_width  = 32;
   localparam int meta_width  = 8;
   localparam int imm_width   = 16;

   // Codes above e_mret are illegal
   typedef enum logic [3:0] {
      e_alu    = 4'd0,
      e_beq    = 4'd1,
      e_bne    = 4'd2,
      e_blt    = 4'd3,
      e_jal    = 4'd4,
      e_jalr   = 4'd5,
      e_fencei = 4'd6,
      e_ecall  = 4'd7,
      e_mret   = 4'd8
   } be_opcode_e;

   // Branch compare kind
   typedef enum logic [1:0] {
      e_cmp_eq = 2'd0,
      e_cmp_ne = 2'd1,
      e_cmp_lt = 2'd2
   } be_cmp_e;

   // Issue packet from the front end
   typedef struct packed {
      logic                   valid;
      logic [vaddr_width-1:0] pc;
      be_opcode_e             opcode;
      logic [imm_width-1:0]   imm;
      logic [data_width-1:0]  rs1;
      logic [data_width-1:0]  rs2;
      logic [meta_width-1:0]  meta;
   } be_issue_s;

   typedef struct packed {
      logic                   valid;
      logic [vaddr_width-1:0] pc;
      logic                   is_branch;
      logic                   is_jump;
      logic                   jump_indirect;
      be_cmp_e                cmp;
      logic                   fencei;
      logic                   trap;
      logic                   ret;
      logic [vaddr_width-1:0] imm;
      logic [data_width-1:0]  rs1;
      logic [data_width-1:0]  rs2;
      logic [meta_width-1:0]  meta;
   } be_decode_s;

   // Resolved instruction as seen by the PC director
   typedef struct packed {
      logic                   ex_v;
      logic [vaddr_width-1:0] ex_pc;
      logic                   br_or_jmp;
      logic                   btaken;
      logic [vaddr_width-1:0] br_tgt;
      logic                   fencei_v;
      logic                   trap_v;
      logic                   ret_v;
      logic [meta_width-1:0]  meta;
   } be_status_s;

endpackage

`default_nettype wire

// ==== src/be_top.sv ====
/*
 * Back-end control top level
 * Decode, execute and the PC director in a fixed three-stage chain
 */
`timescale 1ns/1ps
`default_nettype none

module be_top (
   input  wire logic                                clk_i,
   input  wire logic                                reset_i,
   input  be_isa_pkg::be_issue_s                    issue_i,
   input  fe_cmd_pkg::boot_cfg_s                    boot_cfg_i,
   input  wire logic [be_isa_pkg::vaddr_width-1:0]  tvec_i,
   input  wire logic [be_isa_pkg::vaddr_width-1:0]  epc_i,
   input  wire logic                                fe_cmd_ready_i,
   output fe_cmd_pkg::fe_cmd_s                      fe_cmd_o,
   output logic                                     fe_cmd_v_o,
   output logic                                     flush_o,
   output logic [be_isa_pkg::vaddr_width-1:0]       expected_npc_o,
   output logic [be_isa_pkg::vaddr_width-1:0]       pc_o
);

   be_isa_pkg::be_decode_s dec;
   be_isa_pkg::be_status_s status;

   be_decode decode_inst (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .issue_i (issue_i),
      .dec_o   (dec)
   );

   be_execute execute_inst (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .dec_i    (dec),
      .status_o (status)
   );

   be_director director_inst (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .boot_cfg_i     (boot_cfg_i),
      .status_i       (status),
      .tvec_i         (tvec_i),
      .epc_i          (epc_i),
      .fe_cmd_ready_i (fe_cmd_ready_i),
      .fe_cmd_o       (fe_cmd_o),
      .fe_cmd_v_o     (fe_cmd_v_o),
      .flush_o        (flush_o),
      .expected_npc_o (expected_npc_o),
      .pc_o           (pc_o)
   );

endmodule

`default_nettype wire

// ==== src/fe_cmd_pkg.sv ====
/*
 * Front-end command package
 * Command opcodes, redirect sub-opcodes and reasons, the command
 * bundle and the boot configuration
 */
`default_nettype none

package fe_cmd_pkg;

   typedef enum logic [2:0] {
      e_op_state_reset    = 3'd0,
      e_op_pc_redirection = 3'd1,
      e_op_icache_fence   = 3'd2,
      e_op_attaboy        = 3'd3
   } fe_opcode_e;

   // Only meaningful for redirects
   typedef enum logic [1:0] {
      e_subop_branch_mispredict = 2'd0,
      e_subop_trap              = 2'd1,
      e_subop_ret               = 2'd2
   } fe_subop_e;

   typedef enum logic {
      e_not_a_branch         = 1'b0,
      e_incorrect_prediction = 1'b1
   } fe_reason_e;

   typedef struct packed {
      fe_opcode_e                        opcode;
      logic [be_isa_pkg::vaddr_width-1:0] vaddr;
      fe_subop_e                         subop;
      fe_reason_e                        reason;
      logic [be_isa_pkg::meta_width-1:0]  meta;
   } fe_cmd_s;

   // Freeze holds the core in reset until the boot PC is loaded
   typedef struct packed {
      logic                              freeze;
      logic                              start_pc_w_v;
      logic [be_isa_pkg::vaddr_width-1:0] start_pc;
   } boot_cfg_s;

endpackage

`default_nettype wire
